/* include/gs_params.svh */
// gauss-seidel solver constants
`ifndef GS_PARAMS_SVH
`define GS_PARAMS_SVH

// problem size
`define GS_N        16
`define GS_WORDS    18

// number formats
`define GS_COEF_W   16
`define GS_X_W      32
`define GS_FRAC     16

// limits and address widths
`define GS_MAX_ITER 16
`define GS_MEM_AW   10
`define GS_X_AW     9
`define GS_PROB_W   5
`define GS_IDX_W    4

`endif

/* source/gs_pkg.sv */
// gauss-seidel shared types
`default_nettype none

`include "gs_params.svh"

package gs_pkg;

	typedef logic signed [`GS_COEF_W-1:0] coef_t;  // a_ij, b_i or 1/a_ii in Q0.16
	typedef logic signed [`GS_X_W-1:0]    fix_t;   // x in Q16.16

	// exact sum of 16 coef x fix products
	typedef logic signed [`GS_COEF_W+`GS_X_W+3:0] sum_t;

	typedef coef_t [`GS_N-1:0]         mem_word_t;
	typedef fix_t  [`GS_N-1:0]         x_vec_t;
	typedef logic  [`GS_IDX_W-1:0]     idx_t;

	typedef struct packed {
		logic                  rreq;
		logic [`GS_MEM_AW-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic      vld;
		mem_word_t dout;
	} mem_rsp_t;

	typedef struct packed {
		logic                wen;
		logic [`GS_X_AW-1:0] addr;  // {problem, index}
		fix_t                data;
	} x_write_t;

	typedef struct packed {
		logic                valid;
		logic [`GS_X_AW-1:0] addr;
	} drain_t;

endpackage

`default_nettype wire

/* source/gs_sequencer.sv */
// solver control sequencer
`timescale 1ns/10ps
`default_nettype none

`include "gs_params.svh"

module gs_sequencer (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_module_en,
	input  logic [`GS_PROB_W-1:0] i_matrix_num,
	input  logic                  i_mem_rrdy,
	input  logic                  i_mem_vld,
	input  logic                  i_changed,
	output gs_pkg::mem_req_t      o_mem_req,
	output logic                  o_cap_inv,
	output logic                  o_cap_b,
	output logic                  o_x_we,
	output logic                  o_sweep_start,
	output logic                  o_clear_x,
	output gs_pkg::idx_t          o_row,
	output gs_pkg::drain_t        o_drain,
	output logic                  o_proc_done
);
	import gs_pkg::*;

	localparam int MEM_AW   = `GS_MEM_AW;
	localparam int ITER_W   = $clog2(`GS_MAX_ITER + 1);
	localparam int ROW_BASE = 2;  // words 0 and 1 hold 1/a and b

	typedef enum logic [3:0] {
		IDLE, LOAD_INV, LOAD_B, ROW_REQ, ROW_WAIT, CALC, SWEEP_END, DRAIN, FINISH
	} state_t;

	state_t                 state_r, state_n;
	logic [`GS_PROB_W-1:0]  prob_r, prob_n;
	logic [MEM_AW-1:0]      base_r, base_n;   // problem * 18
	logic [ITER_W-1:0]      iter_r, iter_n;   // completed sweeps
	idx_t                   row_r, row_n;
	idx_t                   drain_r, drain_n;
	mem_req_t               req_r, req_n;
	logic                   done_r;
	logic                   stop;
	logic                   last_prob;

	assign stop      = !i_changed || (iter_r == ITER_W'(`GS_MAX_ITER));
	assign last_prob = (prob_r == i_matrix_num - 1'b1);

	// ------------------------------
	// next state and counters
	// ------------------------------
	always_comb begin
		state_n    = state_r;
		prob_n     = prob_r;
		base_n     = base_r;
		iter_n     = iter_r;
		row_n      = row_r;
		drain_n    = drain_r;
		req_n.rreq = req_r.rreq & ~i_mem_rrdy;  // drops after acceptance
		req_n.addr = req_r.addr;
		case (state_r)
			IDLE: if (i_module_en) begin
				state_n    = LOAD_INV;
				prob_n     = '0;
				base_n     = '0;
				req_n.rreq = 1'b1;
				req_n.addr = '0;
			end
			LOAD_INV: if (i_mem_vld) begin
				state_n    = LOAD_B;
				req_n.rreq = 1'b1;
				req_n.addr = base_r + MEM_AW'(1);
			end
			LOAD_B: if (i_mem_vld) begin
				state_n    = ROW_REQ;
				row_n      = '0;
				iter_n     = '0;
				req_n.rreq = 1'b1;
				req_n.addr = base_r + MEM_AW'(ROW_BASE);
			end
			ROW_REQ: if (i_mem_rrdy) state_n = ROW_WAIT;
			ROW_WAIT: if (i_mem_vld) state_n = CALC;  // row sum registered on this edge
			CALC: begin
				if (row_r == idx_t'(`GS_N - 1)) begin
					state_n = SWEEP_END;
					iter_n  = iter_r + 1'b1;
				end
				else begin
					state_n    = ROW_REQ;
					row_n      = row_r + 1'b1;
					req_n.rreq = 1'b1;
					req_n.addr = base_r + MEM_AW'(ROW_BASE) + MEM_AW'(row_r) + MEM_AW'(1);
				end
			end
			SWEEP_END: begin
				if (stop) begin
					state_n = DRAIN;
					drain_n = '0;
				end
				else begin
					state_n    = ROW_REQ;  // another sweep
					row_n      = '0;
					req_n.rreq = 1'b1;
					req_n.addr = base_r + MEM_AW'(ROW_BASE);
				end
			end
			DRAIN: begin
				drain_n = drain_r + 1'b1;
				if (drain_r == idx_t'(`GS_N - 1)) begin
					if (last_prob) begin
						state_n = FINISH;
					end
					else begin
						state_n    = LOAD_INV;
						prob_n     = prob_r + 1'b1;
						base_n     = base_r + MEM_AW'(`GS_WORDS);
						req_n.rreq = 1'b1;
						req_n.addr = base_r + MEM_AW'(`GS_WORDS);
					end
				end
			end
			FINISH: if (!i_module_en) state_n = IDLE;
			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state_r <= IDLE;
			prob_r  <= '0;
			base_r  <= '0;
			iter_r  <= '0;
			row_r   <= '0;
			drain_r <= '0;
			req_r   <= '0;
			done_r  <= 1'b0;
		end
		else begin
			state_r <= state_n;
			prob_r  <= prob_n;
			base_r  <= base_n;
			iter_r  <= iter_n;
			row_r   <= row_n;
			drain_r <= drain_n;
			req_r   <= req_n;
			done_r  <= (state_r == FINISH) && i_module_en;  // held until enable drops
		end
	end

	// ------------------------------
	// strobes to the datapath
	// ------------------------------
	assign o_mem_req     = req_r;
	assign o_cap_inv     = (state_r == LOAD_INV) && i_mem_vld;
	assign o_cap_b       = (state_r == LOAD_B) && i_mem_vld;
	assign o_x_we        = (state_r == CALC);
	assign o_sweep_start = o_cap_b || ((state_r == SWEEP_END) && !stop);
	assign o_clear_x     = (state_r == LOAD_INV);  // x starts at zero
	assign o_row         = row_r;
	assign o_drain.valid = (state_r == DRAIN);
	assign o_drain.addr  = {prob_r, drain_r};
	assign o_proc_done   = done_r;

	// a stalled request keeps its address until the memory takes it
	assert property (@(posedge i_clk) disable iff (i_reset)
		req_r.rreq && !i_mem_rrdy |=> req_r.rreq && $stable(req_r.addr));

	// read data only while a word is awaited
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_mem_vld |-> state_r inside {LOAD_INV, LOAD_B, ROW_WAIT});

endmodule

`default_nettype wire

/* source/gs_param_store.sv */
// per-problem reciprocal and b store
`timescale 1ns/10ps
`default_nettype none

module gs_param_store (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_cap_inv,
	input  logic              i_cap_b,
	input  gs_pkg::mem_word_t i_word,
	input  gs_pkg::idx_t      i_row,
	output gs_pkg::coef_t     o_inv,
	output gs_pkg::coef_t     o_b
);
	import gs_pkg::*;

	mem_word_t inv_r;  // 1/a_ii per lane
	mem_word_t b_r;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			inv_r <= '0;
			b_r   <= '0;
		end
		else begin
			if (i_cap_inv) inv_r <= i_word;
			if (i_cap_b)   b_r   <= i_word;
		end
	end

	// lane of the row being updated
	assign o_inv = inv_r[i_row];
	assign o_b   = b_r[i_row];

endmodule

`default_nettype wire

/* source/gs_row_dot.sv */
// off-diagonal row dot product
`timescale 1ns/10ps
`default_nettype none

`include "gs_params.svh"

module gs_row_dot (
	input  logic              i_clk,
	input  logic              i_reset,
	input  gs_pkg::mem_word_t i_row_word,
	input  gs_pkg::x_vec_t    i_x,
	input  gs_pkg::idx_t      i_row,
	output gs_pkg::sum_t      o_sum
);
	import gs_pkg::*;

	localparam int NODES = 2 * `GS_N - 1;

	sum_t node [NODES];  // heap-ordered tree, leaves at the top half
	sum_t sum_r;

	always_comb begin
		for (int j = 0; j < `GS_N; j++) begin
			if (j == int'(i_row)) begin
				node[`GS_N-1+j] = '0;  // diagonal lane masked
			end
			else begin
				node[`GS_N-1+j] = i_row_word[j] * i_x[j];
			end
		end
		// pairwise adds down to the root
		for (int k = `GS_N - 2; k >= 0; k--) begin
			node[k] = node[2*k+1] + node[2*k+2];
		end
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) sum_r <= '0;
		else         sum_r <= node[0];  // sampled every cycle, used in CALC
	end

	assign o_sum = sum_r;

endmodule

`default_nettype wire

/* source/gs_row_update.sv */
// x_i update with reciprocal scaling
`timescale 1ns/10ps
`default_nettype none

`include "gs_params.svh"

module gs_row_update (
	input  gs_pkg::sum_t  i_sum,
	input  gs_pkg::coef_t i_b,
	input  gs_pkg::coef_t i_inv,
	output gs_pkg::fix_t  o_x_new
);
	import gs_pkg::*;

	localparam int RES_W  = $bits(sum_t) + 1;
	localparam int PROD_W = RES_W + `GS_COEF_W;

	localparam fix_t FIX_MAX = {1'b0, {(`GS_X_W-1){1'b1}}};
	localparam fix_t FIX_MIN = {1'b1, {(`GS_X_W-1){1'b0}}};

	logic signed [RES_W-1:0]     b_ext;
	logic signed [RES_W-1:0]     resid;
	logic signed [PROD_W-1:0]    scaled;
	logic signed [PROD_W-1:0]    shifted;
	logic [PROD_W-`GS_X_W:0]     top;  // bits that must match the sign

	always_comb begin
		b_ext   = i_b;
		resid   = (b_ext <<< `GS_FRAC) - i_sum;  // b_i in Q.16 minus row sum
		scaled  = resid * i_inv;
		shifted = scaled >>> `GS_FRAC;
		top     = shifted[PROD_W-1:`GS_X_W-1];
	end

	// ------------------------------
	// saturate to 32 bits
	// ------------------------------
	always_comb begin
		if (&top || ~|top) begin
			o_x_new = shifted[`GS_X_W-1:0];
		end
		else if (shifted[PROD_W-1]) begin
			o_x_new = FIX_MIN;  // negative overflow
		end
		else begin
			o_x_new = FIX_MAX;
		end
	end

endmodule

`default_nettype wire

/* source/gs_x_file.sv */
// x vector and result port
`timescale 1ns/10ps
`default_nettype none

`include "gs_params.svh"

module gs_x_file (
	input  logic             i_clk,
	input  logic             i_reset,
	input  logic             i_we,
	input  logic             i_clear,
	input  logic             i_sweep_start,
	input  gs_pkg::idx_t     i_row,
	input  gs_pkg::fix_t     i_x_new,
	input  gs_pkg::drain_t   i_drain,
	output gs_pkg::x_vec_t   o_x,
	output logic             o_changed,
	output gs_pkg::x_write_t o_x_wr
);
	import gs_pkg::*;

	x_vec_t              x_r;
	logic                changed_r;  // sticky over one sweep
	logic                wen_r;
	logic [`GS_X_AW-1:0] waddr_r;
	fix_t                wdata_r;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			x_r <= '0;
		end
		else if (i_clear) begin
			x_r <= '0;
		end
		else if (i_we) begin
			x_r[i_row] <= i_x_new;
		end
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			changed_r <= 1'b0;
		end
		else if (i_clear || i_sweep_start) begin
			changed_r <= 1'b0;
		end
		else if (i_we && (x_r[i_row] != i_x_new)) begin
			changed_r <= 1'b1;
		end
	end

	// ------------------------------
	// result output register
	// ------------------------------
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) wen_r <= 1'b0;
		else         wen_r <= i_drain.valid;
	end

	always_ff @(posedge i_clk) begin
		waddr_r <= i_drain.addr;
		wdata_r <= x_r[i_drain.addr[`GS_IDX_W-1:0]];  // low bits pick the lane
	end

	assign o_x        = x_r;
	assign o_changed  = changed_r;
	assign o_x_wr.wen  = wen_r;
	assign o_x_wr.addr = waddr_r;
	assign o_x_wr.data = wdata_r;

	// row updates and the drain never overlap
	assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_we && i_drain.valid));

endmodule

`default_nettype wire

/* source/gs_solver_top.sv */
// gauss-seidel solver top
`timescale 1ns/10ps
`default_nettype none

`include "gs_params.svh"

module gs_solver_top (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_module_en,
	input  logic [`GS_PROB_W-1:0] i_matrix_num,
	output logic                  o_proc_done,
	output gs_pkg::mem_req_t      o_mem_req,
	input  logic                  i_mem_rrdy,
	input  gs_pkg::mem_rsp_t      i_mem_rsp,
	output gs_pkg::x_write_t      o_x_wr
);
	import gs_pkg::*;

	logic   cap_inv;
	logic   cap_b;
	logic   x_we;
	logic   sweep_start;
	logic   clear_x;
	logic   changed;
	idx_t   row;
	drain_t drain;
	coef_t  inv;
	coef_t  b;
	sum_t   row_sum;
	fix_t   x_new;
	x_vec_t x_vec;

	gs_sequencer u_seq (
		.i_clk(i_clk), .i_reset(i_reset), .i_module_en(i_module_en),
		.i_matrix_num(i_matrix_num), .i_mem_rrdy(i_mem_rrdy), .i_mem_vld(i_mem_rsp.vld),
		.i_changed(changed), .o_mem_req(o_mem_req), .o_cap_inv(cap_inv), .o_cap_b(cap_b),
		.o_x_we(x_we), .o_sweep_start(sweep_start), .o_clear_x(clear_x), .o_row(row),
		.o_drain(drain), .o_proc_done(o_proc_done)
	);

	gs_param_store u_params (
		.i_clk(i_clk), .i_reset(i_reset), .i_cap_inv(cap_inv), .i_cap_b(cap_b),
		.i_word(i_mem_rsp.dout), .i_row(row), .o_inv(inv), .o_b(b)
	);

	gs_row_dot u_dot (
		.i_clk(i_clk), .i_reset(i_reset), .i_row_word(i_mem_rsp.dout), .i_x(x_vec),
		.i_row(row), .o_sum(row_sum)
	);

	gs_row_update u_update (.i_sum(row_sum), .i_b(b), .i_inv(inv), .o_x_new(x_new));

	gs_x_file u_x (
		.i_clk(i_clk), .i_reset(i_reset), .i_we(x_we), .i_clear(clear_x),
		.i_sweep_start(sweep_start), .i_row(row), .i_x_new(x_new), .i_drain(drain),
		.o_x(x_vec), .o_changed(changed), .o_x_wr(o_x_wr)
	);

endmodule

`default_nettype wire

/* bench/gs_solver_tb.sv */
// gauss-seidel solver testbench
`timescale 1ns/10ps
`default_nettype none

`include "gs_params.svh"

module gs_solver_tb;
	import gs_pkg::*;

	localparam int MAX_PROB = 4;

	logic                  clk;
	logic                  reset;
	logic                  module_en;
	logic [`GS_PROB_W-1:0] matrix_num;
	logic                  proc_done;
	mem_req_t              mem_req;
	logic                  mem_rrdy;
	mem_rsp_t              mem_rsp;
	x_write_t              x_wr;

	mem_word_t             mem [1 << `GS_MEM_AW];
	fix_t                  exp_x [MAX_PROB][`GS_N];
	int                    sweeps [MAX_PROB];
	logic [`GS_MEM_AW-1:0] addr_q [$];  // reads in issue order
	x_write_t              wr_q [$];
	int                    num_prob;
	int                    errors = 0;
	int                    last_errors = 0;
	int                    tests = 0;
	int                    failed_tests = 0;
	int                    writes = 0;
	int                    seed = 7;
	bit                    loaded = 0;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	gs_solver_top i_dut (
		.i_clk(clk), .i_reset(reset), .i_module_en(module_en), .i_matrix_num(matrix_num),
		.o_proc_done(proc_done), .o_mem_req(mem_req), .i_mem_rrdy(mem_rrdy),
		.i_mem_rsp(mem_rsp), .o_x_wr(x_wr)
	);

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
		if (got.rreq !== exp.rreq || (exp.rreq && got.addr !== exp.addr)) begin
			$display("error o_mem_req got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic check_x_write(input x_write_t got, input x_write_t exp);
		if (got.wen !== exp.wen || (exp.wen && (got.addr !== exp.addr
				|| got.data !== exp.data))) begin
			$display("error o_x_wr got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp) begin
			$display("error o_proc_done got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		if (errors == last_errors) begin
			$display("%s: ok", name);
		end
		else begin
			$display("%s: %0d errors", name, errors - last_errors);
			failed_tests++;
		end
		last_errors = errors;
		tests++;
	endtask

	// ------------------------------
	// trace file and expectations
	// ------------------------------
	task automatic load_trace();
		int          fd;
		int          n;
		string       line;
		logic [15:0] lane;
		fix_t        xv;
		for (int a = 0; a < (1 << `GS_MEM_AW); a++) begin
			mem[a] = {`GS_N{16'hA000 ^ 16'(a)}};  // unused words
		end
		fd = $fopen("bench/gs_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/gs_trace.txt");
			errors++;
		end
		else begin
			n = $fgets(line, fd);  // two comment lines
			n = $fgets(line, fd);
			n = $fscanf(fd, "%d", num_prob);
			for (int p = 0; p < num_prob; p++) begin
				for (int w = 0; w < `GS_WORDS; w++) begin
					for (int l = 0; l < `GS_N; l++) begin
						n = $fscanf(fd, "%h", lane);
						mem[p * `GS_WORDS + w][l] = lane;
					end
				end
				n = $fscanf(fd, "%d", sweeps[p]);
				for (int l = 0; l < `GS_N; l++) begin
					n = $fscanf(fd, "%h", xv);
					exp_x[p][l] = xv;
				end
			end
			if (n != 1) begin
				$display("trace file bench/gs_trace.txt ended early");
				errors++;
			end
			$fclose(fd);
		end
	endtask

	task automatic expect_sequence();
		int       base;
		x_write_t wr;
		for (int p = 0; p < num_prob; p++) begin
			base = p * `GS_WORDS;
			addr_q.push_back(base);
			addr_q.push_back(base + 1);
			for (int s = 0; s < sweeps[p]; s++) begin
				for (int r = 0; r < `GS_N; r++) addr_q.push_back(base + 2 + r);
			end
			for (int l = 0; l < `GS_N; l++) begin
				wr.wen  = 1'b1;
				wr.addr = p * `GS_N + l;  // {problem, index}
				wr.data = exp_x[p][l];
				wr_q.push_back(wr);
			end
		end
	endtask

	// ------------------------------
	// memory model
	// ------------------------------
	initial begin : memory_model
		logic                  accepted;
		mem_req_t              req_seen;
		logic [`GS_MEM_AW-1:0] rsp_addr;
		int                    wait_cnt;
		bit                    pending;
		accepted = 1'b0;
		req_seen = '0;
		rsp_addr = '0;
		wait_cnt = 0;
		pending  = 1'b0;
		@(negedge reset);
		forever begin
			@(negedge clk);
			accepted = mem_req.rreq && mem_rrdy;  // taken at the coming edge
			req_seen = mem_req;
			@(posedge clk);
			#1;
			mem_rsp.vld = 1'b0;
			if (pending) begin
				wait_cnt--;
				if (wait_cnt == 0) begin
					mem_rsp.vld  = 1'b1;
					mem_rsp.dout = mem[rsp_addr];
					pending      = 1'b0;
				end
			end
			if (accepted) begin
				if (addr_q.size() == 0) begin
					$display("read of address %h beyond the expected sequence", req_seen.addr);
					errors++;
				end
				else begin
					check_mem_req(req_seen, {1'b1, addr_q.pop_front()});
				end
				pending  = 1'b1;
				rsp_addr = req_seen.addr;
				wait_cnt = 1 + {$random(seed)} % 4;
			end
			mem_rrdy = !pending && ({$random(seed)} % 4 != 0);  // random gaps
		end
	end

	initial begin : result_monitor
		x_write_t exp;
		@(negedge reset);
		forever begin
			@(negedge clk);
			if (x_wr.wen === 1'b1) begin
				if (wr_q.size() == 0) begin
					$display("unexpected result write at address %h", x_wr.addr);
					errors++;
				end
				else begin
					exp = wr_q.pop_front();
					check_x_write(x_wr, exp);
				end
				writes++;
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = num_prob * (2 + `GS_N * `GS_MAX_ITER) * 8 + 100;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, the solver never finished", limit);
		$display("Test failed");
		$finish;
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : main_flow
		reset      = 1'b1;
		module_en  = 1'b0;
		matrix_num = '0;
		mem_rrdy   = 1'b0;
		mem_rsp    = '0;
		load_trace();
		expect_sequence();
		matrix_num = num_prob;
		loaded     = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_mem_req(mem_req, '0);
			check_x_write(x_wr, '0);
			check_done(proc_done, 1'b0);
		end
		report_test("reset state");

		@(posedge clk);
		#1 module_en = 1'b1;
		for (int p = 0; p < num_prob; p++) begin
			wait (writes >= (p + 1) * `GS_N);
			report_test($sformatf("problem %0d results", p));
		end

		// done follows the last write by one cycle
		check_done(proc_done, 1'b0);
		repeat (4) begin
			@(negedge clk);
			check_done(proc_done, 1'b1);
		end
		@(posedge clk);
		#1 module_en = 1'b0;
		repeat (2) @(negedge clk);
		check_done(proc_done, 1'b0);
		repeat (10) begin
			@(negedge clk);
			check_mem_req(mem_req, '0);
			check_done(proc_done, 1'b0);
		end
		if (addr_q.size() != 0) begin
			$display("%0d expected reads were never issued", addr_q.size());
			errors++;
		end
		if (wr_q.size() != 0) begin
			$display("%0d expected result writes never appeared", wr_q.size());
			errors++;
		end
		report_test("completion");

		$display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Test passed");
		end
		else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* gs_solver_top.f */
+incdir+include
source/gs_pkg.sv
source/gs_sequencer.sv
source/gs_param_store.sv
source/gs_row_dot.sv
source/gs_row_update.sv
source/gs_x_file.sv
source/gs_solver_top.sv
bench/gs_solver_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the solver testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module gs_solver_tb \
	-f gs_solver_top.f -o gs_sim > build.log 2>&1 \
	&& ./obj_dir/gs_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log \
	&& { echo "simulation reported a failure"; exit 1; } \
	|| { echo "simulation finished without failures"; exit 0; }

/* bench/gs_trace.txt */
# problem count; per problem 18 words (1/a_ii, b, rows 0-15), sweep count, expected x
# word columns are lanes 0 to 15 in hex; expected x is lanes 0-7 then lanes 8-15
3
4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000
0004 0004 0004 0004 0004 0004 0004 0004 0004 0004 0004 0004 0004 0004 0004 0004
0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0001 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0001 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0001 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0001 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0001 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0001 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0001 0004 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0001 0004 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0001 0004 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0004 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0004 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0004 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0004 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0004 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0004
2
00010000 0000C000 0000D000 0000CC00 0000CD00 0000CCC0 0000CCD0 0000CCCC
0000CCCD 0000CCCC 0000CCCD 0000CCCC 0000CCCD 0000CCCC 0000CCCD 0000CCCC
4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000
0004 0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 0004
0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0004
0000 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0004 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0004 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0004 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0004 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0004 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0004 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0004 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0004 0000
FFFC 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0004
16
FFFF0000 00004000 00008000 0000C000 00010000 00014000 00018000 0001C000
00020000 00024000 00028000 0002C000 00030000 00034000 00038000 00000000
7FFF 7FFF 7FFF 0001 0100 0100 0100 0100 0100 0100 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
7FFF 7FFF 8000 0000 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 8000 8000 8000 8000 8000 8000
0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
8000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
7FFF 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0001 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001
2
3FFF0001 7FFFFFFF 80000000 FFFF8000 007FFF00 007FFF00 007FFF00 007FFF00
007FFF00 007FFF00 C0008000 C0008000 C0008000 C0008000 C0008000 C0008000
